// File: rtl/exu_cfg.svh
`ifndef EXU_CFG_SVH
`define EXU_CFG_SVH

// datapath
`define EXU_XLEN 32
`define EXU_WMASK_W 8

// cycles from in_valid to out_valid
`define EXU_LAT 2

// reset and commit values
`define EXU_RST_WORD {`EXU_XLEN{1'b0}}
`define EXU_LINK_OFS 4

`endif

// File: rtl/rv_isa_pkg.sv
package rv_isa_pkg;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} rv_r_fmt_t;

	typedef struct packed {
		logic [11:0] imm_11_0;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} rv_i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_11_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_4_0;
		logic [6:0] opcode;
	} rv_s_fmt_t;

	typedef struct packed {
		logic       imm_12;
		logic [5:0] imm_10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm_4_1;
		logic       imm_11;
		logic [6:0] opcode;
	} rv_b_fmt_t;

	typedef struct packed {
		logic [19:0] imm_31_12;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} rv_u_fmt_t;

	typedef struct packed {
		logic       imm_20;
		logic [9:0] imm_10_1;
		logic       imm_11;
		logic [7:0] imm_19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} rv_j_fmt_t;

	// one word read in six formats
	typedef union packed {
		rv_r_fmt_t r;
		rv_i_fmt_t i;
		rv_s_fmt_t s;
		rv_b_fmt_t b;
		rv_u_fmt_t u;
		rv_j_fmt_t j;
	} rv_inst_u;

endpackage

// File: rtl/exu_pkg.sv
`include "exu_cfg.svh"

package exu_pkg;

	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

	localparam logic [2:0] F3_ADD   = 3'b000; // also sub
	localparam logic [2:0] F3_SLL   = 3'b001;
	localparam logic [2:0] F3_SLT   = 3'b010;
	localparam logic [2:0] F3_SLTU  = 3'b011;
	localparam logic [2:0] F3_XOR   = 3'b100;
	localparam logic [2:0] F3_SR    = 3'b101; // srl/sra
	localparam logic [2:0] F3_OR    = 3'b110;
	localparam logic [2:0] F3_AND   = 3'b111;
	localparam logic [2:0] F3_JALR  = 3'b000;
	localparam logic [2:0] F3_BEQ   = 3'b000;
	localparam logic [2:0] F3_BNE   = 3'b001;
	localparam logic [2:0] F3_BLT   = 3'b100;
	localparam logic [2:0] F3_BGE   = 3'b101;
	localparam logic [2:0] F3_BLTU  = 3'b110;
	localparam logic [2:0] F3_BGEU  = 3'b111;
	localparam logic [2:0] F3_SB    = 3'b000;
	localparam logic [2:0] F3_SH    = 3'b001;
	localparam logic [2:0] F3_SW    = 3'b010;
	localparam logic [2:0] F3_CSRRW = 3'b001;
	localparam logic [2:0] F3_CSRRS = 3'b010;

	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT  = 7'b0100000;

	localparam logic [`EXU_WMASK_W-1:0] WMASK_B = `EXU_WMASK_W'h01;
	localparam logic [`EXU_WMASK_W-1:0] WMASK_H = `EXU_WMASK_W'h03;
	localparam logic [`EXU_WMASK_W-1:0] WMASK_W = `EXU_WMASK_W'h0f;

endpackage

// File: rtl/exu_decode.sv
`timescale 1ns/1ps
`include "exu_cfg.svh"

module exu_decode import rv_isa_pkg::*, exu_pkg::*; (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 in_valid,
	input  logic [`EXU_XLEN-1:0] inst,
	input  logic [`EXU_XLEN-1:0] pc,
	input  logic [`EXU_XLEN-1:0] src1,
	input  logic [`EXU_XLEN-1:0] src2,
	input  logic [`EXU_XLEN-1:0] csr_val,
	output logic                 s1_valid,
	output logic [6:0]           s1_opcode,
	output logic [2:0]           s1_funct3,
	output logic [6:0]           s1_funct7,
	output logic [`EXU_XLEN-1:0] s1_pc,
	output logic [`EXU_XLEN-1:0] s1_src1,
	output logic [`EXU_XLEN-1:0] s1_src2,
	output logic [`EXU_XLEN-1:0] s1_csr_val,
	output logic [`EXU_XLEN-1:0] s1_imm
);

	rv_inst_u s1_inst;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			s1_valid <= 1'b0;
		end else begin
			s1_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			s1_inst    <= inst;
			s1_pc      <= pc;
			s1_src1    <= src1;
			s1_src2    <= src2;
			s1_csr_val <= csr_val;
		end
	end

	// same bits in every format
	assign s1_opcode = s1_inst.r.opcode;
	assign s1_funct3 = s1_inst.r.funct3;
	assign s1_funct7 = s1_inst.r.funct7;

	always_comb begin
		case (s1_opcode)
			OPC_OP_IMM, OPC_JALR: s1_imm = {{(`EXU_XLEN-12){s1_inst.i.imm_11_0[11]}},
				s1_inst.i.imm_11_0};
			OPC_STORE: s1_imm = {{(`EXU_XLEN-12){s1_inst.s.imm_11_5[6]}},
				s1_inst.s.imm_11_5, s1_inst.s.imm_4_0};
			OPC_BRANCH: s1_imm = {{(`EXU_XLEN-13){s1_inst.b.imm_12}}, s1_inst.b.imm_12,
				s1_inst.b.imm_11, s1_inst.b.imm_10_5, s1_inst.b.imm_4_1, 1'b0};
			OPC_LUI, OPC_AUIPC: s1_imm = {s1_inst.u.imm_31_12, 12'b0};
			OPC_JAL: s1_imm = {{(`EXU_XLEN-21){s1_inst.j.imm_20}}, s1_inst.j.imm_20,
				s1_inst.j.imm_19_12, s1_inst.j.imm_11, s1_inst.j.imm_10_1, 1'b0};
			default: s1_imm = '0; // no immediate
		endcase
	end

endmodule

// File: rtl/exu_alu.sv
`timescale 1ns/1ps
`include "exu_cfg.svh"

module exu_alu import exu_pkg::*; (
	input  logic [6:0]           s1_opcode,
	input  logic [2:0]           s1_funct3,
	input  logic [6:0]           s1_funct7,
	input  logic [`EXU_XLEN-1:0] s1_pc,
	input  logic [`EXU_XLEN-1:0] s1_src1,
	input  logic [`EXU_XLEN-1:0] s1_src2,
	input  logic [`EXU_XLEN-1:0] s1_imm,
	input  logic [`EXU_XLEN-1:0] s1_csr_val,
	output logic [`EXU_XLEN-1:0] alu_val,
	output logic [`EXU_XLEN-1:0] alu_csr_wdata
);

	logic                 is_op;
	logic                 alt;
	logic                 is_shift;
	logic                 f7_ok;
	logic                 arith_ok;
	logic [`EXU_XLEN-1:0] opb;
	logic [4:0]           shamt;
	logic [`EXU_XLEN-1:0] arith;

	assign is_op    = (s1_opcode == OPC_OP);
	assign alt      = (s1_funct7 == F7_ALT);
	assign is_shift = (s1_funct3 == F3_SLL) || (s1_funct3 == F3_SR);
	assign opb      = is_op ? s1_src2 : s1_imm;
	assign shamt    = opb[4:0];

	// alt funct7 only for sub, sra, srai
	assign f7_ok = (s1_funct7 == F7_BASE) ||
		(alt && ((s1_funct3 == F3_SR) || (is_op && s1_funct3 == F3_ADD)));
	assign arith_ok = (is_op || is_shift) ? f7_ok : 1'b1;

	always_comb begin
		case (s1_funct3)
			F3_ADD:  arith = (is_op && alt) ? s1_src1 - opb : s1_src1 + opb;
			F3_SLL:  arith = s1_src1 << shamt;
			F3_SLT:  arith = {{(`EXU_XLEN-1){1'b0}}, $signed(s1_src1) < $signed(opb)};
			F3_SLTU: arith = {{(`EXU_XLEN-1){1'b0}}, s1_src1 < opb};
			F3_XOR:  arith = s1_src1 ^ opb;
			F3_SR:   arith = alt ? $unsigned($signed(s1_src1) >>> shamt) : s1_src1 >> shamt;
			F3_OR:   arith = s1_src1 | opb;
			default: arith = s1_src1 & opb;
		endcase
	end

	always_comb begin
		alu_val = '0;
		case (s1_opcode)
			OPC_LUI:   alu_val = s1_imm;
			OPC_AUIPC: alu_val = s1_pc + s1_imm;
			OPC_JAL:   alu_val = s1_pc + `EXU_LINK_OFS; // link
			OPC_JALR:  alu_val = (s1_funct3 == F3_JALR) ? s1_pc + `EXU_LINK_OFS : '0;
			OPC_OP_IMM, OPC_OP: alu_val = arith_ok ? arith : '0;
			default:   alu_val = '0;
		endcase
	end

	always_comb begin
		alu_csr_wdata = '0;
		if (s1_opcode == OPC_SYSTEM) begin
			if (s1_funct3 == F3_CSRRW)
				alu_csr_wdata = s1_src1;
			else if (s1_funct3 == F3_CSRRS)
				alu_csr_wdata = s1_src1 | s1_csr_val; // set bits
		end
	end

endmodule

// File: rtl/exu_branch.sv
`timescale 1ns/1ps
`include "exu_cfg.svh"

module exu_branch import exu_pkg::*; (
	input  logic [6:0]           s1_opcode,
	input  logic [2:0]           s1_funct3,
	input  logic [`EXU_XLEN-1:0] s1_pc,
	input  logic [`EXU_XLEN-1:0] s1_src1,
	input  logic [`EXU_XLEN-1:0] s1_src2,
	input  logic [`EXU_XLEN-1:0] s1_imm,
	output logic                 br_taken,
	output logic [`EXU_XLEN-1:0] br_target
);

	localparam int MSB = `EXU_XLEN - 1;

	logic [`EXU_XLEN-1:0] diff;
	logic                 eq;
	logic                 lt;
	logic                 ltu;

	assign diff = s1_src1 - s1_src2;
	assign eq   = (diff == '0);
	assign ltu  = (s1_src1 < s1_src2);
	// sign of src1 when signs differ and sign of diff otherwise
	assign lt = (s1_src1[MSB] & ~s1_src2[MSB]) |
		(~(s1_src1[MSB] ^ s1_src2[MSB]) & diff[MSB]);

	always_comb begin
		br_taken  = 1'b0;
		br_target = s1_pc + s1_imm;
		case (s1_opcode)
			OPC_JAL: br_taken = 1'b1;
			OPC_JALR: begin
				br_taken  = (s1_funct3 == F3_JALR);
				br_target = (s1_src1 + s1_imm) & ~`EXU_XLEN'd1; // lsb cleared
			end
			OPC_BRANCH: begin
				case (s1_funct3)
					F3_BEQ:  br_taken = eq;
					F3_BNE:  br_taken = ~eq;
					F3_BLT:  br_taken = lt;
					F3_BGE:  br_taken = ~lt;
					F3_BLTU: br_taken = ltu;
					F3_BGEU: br_taken = ~ltu;
					default: br_taken = 1'b0;
				endcase
			end
			default: br_taken = 1'b0;
		endcase
	end

endmodule

// File: rtl/exu_commit.sv
`timescale 1ns/1ps
`include "exu_cfg.svh"

module exu_commit import exu_pkg::*; (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    s1_valid,
	input  logic [6:0]              s1_opcode,
	input  logic [2:0]              s1_funct3,
	input  logic [`EXU_XLEN-1:0]    alu_val,
	input  logic [`EXU_XLEN-1:0]    alu_csr_wdata,
	input  logic                    br_taken,
	input  logic [`EXU_XLEN-1:0]    br_target,
	output logic                    out_valid,
	output logic [`EXU_XLEN-1:0]    val,
	output logic [`EXU_XLEN-1:0]    jump,
	output logic                    jump_taken,
	output logic [`EXU_XLEN-1:0]    csr_wdata,
	output logic [`EXU_WMASK_W-1:0] wmask
);

	logic [`EXU_WMASK_W-1:0] s1_wmask;

	always_comb begin
		s1_wmask = '0;
		if (s1_opcode == OPC_STORE) begin
			case (s1_funct3)
				F3_SB:   s1_wmask = WMASK_B;
				F3_SH:   s1_wmask = WMASK_H;
				F3_SW:   s1_wmask = WMASK_W;
				default: s1_wmask = '0; // no such store
			endcase
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_valid  <= 1'b0;
			jump_taken <= 1'b0;
			val        <= `EXU_RST_WORD;
			jump       <= `EXU_RST_WORD;
			csr_wdata  <= `EXU_RST_WORD;
			wmask      <= '0;
		end else begin
			out_valid  <= s1_valid;
			jump_taken <= s1_valid & br_taken; // strobe with out_valid
			if (s1_valid) begin
				val       <= alu_val;
				jump      <= br_taken ? br_target : `EXU_RST_WORD;
				csr_wdata <= alu_csr_wdata;
				wmask     <= s1_wmask;
			end
		end
	end

endmodule

// File: rtl/exu_top.sv
`timescale 1ns/1ps
`include "exu_cfg.svh"

module exu_top (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    in_valid,
	input  logic [`EXU_XLEN-1:0]    inst,
	input  logic [`EXU_XLEN-1:0]    pc,
	input  logic [`EXU_XLEN-1:0]    src1,
	input  logic [`EXU_XLEN-1:0]    src2,
	input  logic [`EXU_XLEN-1:0]    csr_val,
	output logic                    out_valid,
	output logic [`EXU_XLEN-1:0]    val,
	output logic [`EXU_XLEN-1:0]    jump,
	output logic                    jump_taken,
	output logic [`EXU_XLEN-1:0]    csr_wdata,
	output logic [`EXU_WMASK_W-1:0] wmask
);

	logic                 s1_valid;
	logic [6:0]           s1_opcode;
	logic [2:0]           s1_funct3;
	logic [6:0]           s1_funct7;
	logic [`EXU_XLEN-1:0] s1_pc;
	logic [`EXU_XLEN-1:0] s1_src1;
	logic [`EXU_XLEN-1:0] s1_src2;
	logic [`EXU_XLEN-1:0] s1_csr_val;
	logic [`EXU_XLEN-1:0] s1_imm;
	logic [`EXU_XLEN-1:0] alu_val;
	logic [`EXU_XLEN-1:0] alu_csr_wdata;
	logic                 br_taken;
	logic [`EXU_XLEN-1:0] br_target;

	exu_decode u_decode (
		.clk, .arst_n, .in_valid, .inst, .pc, .src1, .src2, .csr_val,
		.s1_valid, .s1_opcode, .s1_funct3, .s1_funct7,
		.s1_pc, .s1_src1, .s1_src2, .s1_csr_val, .s1_imm
	);

	exu_alu u_alu (
		.s1_opcode, .s1_funct3, .s1_funct7, .s1_pc, .s1_src1, .s1_src2,
		.s1_imm, .s1_csr_val, .alu_val, .alu_csr_wdata
	);

	exu_branch u_branch (
		.s1_opcode, .s1_funct3, .s1_pc, .s1_src1, .s1_src2, .s1_imm,
		.br_taken, .br_target
	);

	exu_commit u_commit (
		.clk, .arst_n, .s1_valid, .s1_opcode, .s1_funct3,
		.alu_val, .alu_csr_wdata, .br_taken, .br_target,
		.out_valid, .val, .jump, .jump_taken, .csr_wdata, .wmask
	);

endmodule

// File: bench/exu_asserts.sv
`timescale 1ns/1ps
`include "exu_cfg.svh"

module exu_asserts (
	input logic clk,
	input logic arst_n,
	input logic in_valid,
	input logic out_valid,
	input logic jump_taken
);

	a_latency: assert property (@(posedge clk) disable iff (!arst_n)
		out_valid == $past(in_valid, `EXU_LAT))
		else $error("out_valid does not follow in_valid by %0d cycles", `EXU_LAT);

	a_taken_valid: assert property (@(posedge clk) disable iff (!arst_n)
		jump_taken |-> out_valid)
		else $error("jump_taken high without out_valid");

	// async reset must hold the output stage idle
	a_reset_idle: assert property (@(posedge clk) !arst_n |-> !out_valid)
		else $error("out_valid high during reset");

endmodule

bind exu_top exu_asserts u_asserts (
	.clk(clk),
	.arst_n(arst_n),
	.in_valid(in_valid),
	.out_valid(out_valid),
	.jump_taken(jump_taken)
);

// File: bench/exu_tb.sv
`timescale 1ns/1ps
`include "exu_cfg.svh"

module exu_tb import exu_pkg::*; ();

	localparam int N_INST = 2000;
	localparam int TIMEOUT_CYC = 3 * N_INST + 100;
	localparam int DRV_DLY = 1;
	localparam logic [31:0] SEED = 32'hc0248fed;

	logic clk;
	logic arst_n;
	logic in_valid;
	logic [`EXU_XLEN-1:0] inst, pc, src1, src2, csr_val;
	logic out_valid;
	logic jump_taken;
	logic [`EXU_XLEN-1:0] val, jump, csr_wdata;
	logic [`EXU_WMASK_W-1:0] wmask;

	logic [`EXU_XLEN-1:0] exp_val_q[$];
	logic [`EXU_XLEN-1:0] exp_jump_q[$];
	logic [`EXU_XLEN-1:0] exp_csr_q[$];
	logic exp_taken_q[$];
	logic [`EXU_WMASK_W-1:0] exp_mask_q[$];
	int cycles = 0;

	exu_top DUT (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_word(input string name, input logic [`EXU_XLEN-1:0] got,
		input logic [`EXU_XLEN-1:0] exp);
		if (got !== exp)
			stop_on_error($sformatf("Error at %0d ns: %s is %h, expected %h", $time, name, got, exp));
	endtask

	task automatic check_mask(input string name, input logic [`EXU_WMASK_W-1:0] got,
		input logic [`EXU_WMASK_W-1:0] exp);
		if (got !== exp)
			stop_on_error($sformatf("Error at %0d ns: %s is %h, expected %h", $time, name, got, exp));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			stop_on_error($sformatf("Error at %0d ns: %s is %b, expected %b", $time, name, got, exp));
	endtask

	// boundary values show up often
	function automatic logic [`EXU_XLEN-1:0] rand_operand();
		logic [31:0] r;
		r = $urandom();
		case (r[3:0])
			4'd0: return 32'h0000_0000;
			4'd1: return 32'h7fff_ffff;
			4'd2: return 32'h8000_0000;
			4'd3: return 32'hffff_ffff;
			4'd4: return 32'h0000_0001;
			default: return $urandom();
		endcase
	endfunction

	function automatic logic [31:0] gen_inst();
		logic [31:0] w;
		logic [31:0] r;
		int kind;
		w = $urandom();
		r = $urandom();
		kind = $urandom_range(9);
		if (r[31:24] < 8'd13)
			return w; // about 5% raw words
		case (kind)
			0: w[6:0] = OPC_LUI;
			1: w[6:0] = OPC_AUIPC;
			2: w[6:0] = OPC_JAL;
			3: begin
				w[6:0] = OPC_JALR;
				w[14:12] = F3_JALR;
			end
			4: begin
				w[6:0] = OPC_BRANCH;
				w[14:12] = (r[2:1] == 2'b01) ? {1'b1, r[5:4]} : r[2:0];
			end
			5: begin
				w[6:0] = OPC_OP_IMM;
				if (w[14:12] == F3_SLL)
					w[31:25] = F7_BASE;
				else if (w[14:12] == F3_SR)
					w[31:25] = r[8] ? F7_ALT : F7_BASE;
			end
			6, 7: begin
				w[6:0] = OPC_OP;
				w[31:25] = (r[8] && (w[14:12] == F3_ADD || w[14:12] == F3_SR)) ? F7_ALT : F7_BASE;
			end
			8: begin
				w[6:0] = OPC_STORE;
				w[14:12] = (r[10:9] == 2'b11) ? F3_SW : {1'b0, r[10:9]};
			end
			default: begin
				w[6:0] = OPC_SYSTEM;
				w[14:12] = r[11] ? F3_CSRRS : F3_CSRRW;
			end
		endcase
		return w;
	endfunction

	task automatic model_exec(input logic [31:0] w, input logic [`EXU_XLEN-1:0] a_pc, a, b, csr,
		output logic [`EXU_XLEN-1:0] e_val, e_jump, e_csr, output logic e_taken,
		output logic [`EXU_WMASK_W-1:0] e_mask);
		logic [6:0] opc;
		logic [2:0] f3;
		logic [6:0] f7;
		logic [`EXU_XLEN-1:0] imm_i, imm_b, imm_u, imm_j, opb, tgt, res;
		logic legal;
		logic slt;
		opc = w[6:0];
		f3 = w[14:12];
		f7 = w[31:25];
		imm_i = {{20{w[31]}}, w[31:20]};
		imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
		imm_u = {w[31:12], 12'h000};
		imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
		opb = (opc == OPC_OP) ? b : imm_i;
		legal = (f7 == F7_BASE) || (f7 == F7_ALT && (f3 == F3_SR || (opc == OPC_OP && f3 == F3_ADD)));
		if (opc == OPC_OP_IMM && f3 != F3_SLL && f3 != F3_SR)
			legal = 1'b1; // funct7 bits are immediate here
		slt = (a[31] != opb[31]) ? a[31] : (a < opb);
		case (f3)
			F3_ADD: res = (opc == OPC_OP && f7 == F7_ALT) ? a - opb : a + opb;
			F3_SLL: res = a << opb[4:0];
			F3_SLT: res = {{(`EXU_XLEN-1){1'b0}}, slt};
			F3_SLTU: res = {{(`EXU_XLEN-1){1'b0}}, a < opb};
			F3_XOR: res = a ^ opb;
			F3_SR: res = (a >> opb[4:0]) |
				((f7 == F7_ALT && a[31]) ? ~({`EXU_XLEN{1'b1}} >> opb[4:0]) : '0);
			F3_OR: res = a | opb;
			default: res = a & opb;
		endcase
		e_val = '0;
		e_csr = '0;
		e_taken = 1'b0;
		e_mask = '0;
		tgt = a_pc + imm_b;
		case (opc)
			OPC_LUI: e_val = imm_u;
			OPC_AUIPC: e_val = a_pc + imm_u;
			OPC_JAL: begin
				e_val = a_pc + 4;
				e_taken = 1'b1;
				tgt = a_pc + imm_j;
			end
			OPC_JALR: begin
				if (f3 == F3_JALR) begin
					e_val = a_pc + 4;
					e_taken = 1'b1;
					tgt = a + imm_i;
					tgt[0] = 1'b0;
				end
			end
			OPC_BRANCH: begin
				case (f3)
					F3_BEQ: e_taken = (a == b);
					F3_BNE: e_taken = (a != b);
					F3_BLT: e_taken = ($signed(a) < $signed(b));
					F3_BGE: e_taken = ($signed(a) >= $signed(b));
					F3_BLTU: e_taken = (a < b);
					F3_BGEU: e_taken = (a >= b);
					default: e_taken = 1'b0;
				endcase
			end
			OPC_OP, OPC_OP_IMM: e_val = legal ? res : '0;
			OPC_STORE: begin
				if (f3 == 3'b000)
					e_mask = 8'h01;
				else if (f3 == 3'b001)
					e_mask = 8'h03;
				else if (f3 == 3'b010)
					e_mask = 8'h0f;
			end
			OPC_SYSTEM: begin
				if (f3 == F3_CSRRW)
					e_csr = a;
				else if (f3 == F3_CSRRS)
					e_csr = a | csr;
			end
			default: e_val = '0;
		endcase
		e_jump = e_taken ? tgt : '0;
	endtask

	initial begin
		logic [`EXU_XLEN-1:0] e_val, e_jump, e_csr;
		logic e_taken;
		logic [`EXU_WMASK_W-1:0] e_mask;
		int sent;
		void'($urandom(SEED));
		arst_n = 1'b0;
		in_valid = 1'b0;
		inst = '0;
		pc = '0;
		src1 = '0;
		src2 = '0;
		csr_val = '0;
		sent = 0;
		repeat (8) @(posedge clk);
		#(DRV_DLY) arst_n = 1'b1;
		while (sent < N_INST) begin
			@(posedge clk);
			#(DRV_DLY);
			in_valid = ($urandom_range(99) < 75);
			inst = gen_inst();
			pc = $urandom();
			src1 = rand_operand();
			src2 = rand_operand();
			csr_val = $urandom();
			if (inst[6:0] == OPC_BRANCH && src1[1:0] == 2'b00)
				src2 = src1; // give beq/bge an equal case
			if (in_valid) begin
				model_exec(inst, pc, src1, src2, csr_val, e_val, e_jump, e_csr, e_taken, e_mask);
				exp_val_q.push_back(e_val);
				exp_jump_q.push_back(e_jump);
				exp_csr_q.push_back(e_csr);
				exp_taken_q.push_back(e_taken);
				exp_mask_q.push_back(e_mask);
				sent++;
			end
		end
		@(posedge clk);
		#(DRV_DLY) in_valid = 1'b0;
		repeat (`EXU_LAT + 1) @(posedge clk);
		@(negedge clk);
		if (exp_val_q.size() != 0)
			stop_on_error($sformatf("%0d instructions never produced a result", exp_val_q.size()));
		else begin
			$display("Simulation passed");
			$finish;
		end
	end

	// outputs are stable mid cycle
	always @(negedge clk) begin
		if (arst_n && out_valid) begin
			if (exp_val_q.size() == 0)
				stop_on_error("out_valid was high with no instruction in flight");
			else begin
				check_word("val", val, exp_val_q.pop_front());
				check_word("jump", jump, exp_jump_q.pop_front());
				check_word("csr_wdata", csr_wdata, exp_csr_q.pop_front());
				check_flag("jump_taken", jump_taken, exp_taken_q.pop_front());
				check_mask("wmask", wmask, exp_mask_q.pop_front());
			end
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYC)
			stop_on_error($sformatf("timeout after %0d cycles without finishing", cycles));
	end

endmodule

// File: exu.f
+incdir+rtl
rtl/rv_isa_pkg.sv
rtl/exu_pkg.sv
rtl/exu_decode.sv
rtl/exu_alu.sv
rtl/exu_branch.sv
rtl/exu_commit.sv
rtl/exu_top.sv
bench/exu_asserts.sv
bench/exu_tb.sv

// File: Makefile
VERILATOR ?= verilator
FILELIST  ?= exu.f
TOP       ?= exu_tb
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Simulation passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# pass only if the run printed the pass message
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
